// File: verif/cache_golden.txt
# kind addr_or_sel data expect (hex); R data = done latency, 0 any, F held by full sampler
# W data = write data, C addr = comm select, K pulses the sampler clear
C 0 0 00000000
R 0102 0 A5A50102
R 0101 2 A5A50101
W 0103 11110103 0
R 0103 2 11110103
W 0100 22220100 0
R 0202 0 A5A50202
R 0303 0 A5A50303
R 0401 0 A5A50401
R 0500 0 A5A50500
R 0103 0 11110103
R 0100 2 22220100
C 0 0 0000000B
C 1 0 00000006
C 2 0 00000001
C 6 0 0CA50001
W 0302 33330302 0
R 0600 0 A5A50600
R 0302 0 33330302
R 0501 2 A5A50501
R 0601 2 A5A50601
C 7 0 00000001
C 3 0 00000004
C 4 0 00000601
C 5 0 0000043C
R 0502 F A5A50502
C 7 0 00000001
K 0 0 0
C 7 0 00000000
C 3 0 00000004
C 0 0 00000011
C 1 0 00000008
C 2 0 00000002

// File: flist.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/comm_pkg.sv
verilog/tag_cam.sv
verilog/data_ram.sv
verilog/cache_controller.sv
verilog/ref_sampler.sv
verilog/perf_comm.sv
verilog/cache_sampler_top.sv
verif/cache_assertions.sv
verif/tb_cache_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_cache_top;
	import comm_pkg::*;

	localparam int          DONE_TIMEOUT = 200;	// cycles to cover writeback and refill
	localparam int          QUIET_CYCLES = 16;	// no done expected while held
	localparam logic [31:0] HELD         = 32'hF;	// latency code for a request held by a full sampler
	localparam int          MEM_WORDS    = 2 ** `ADDR_W;

	logic               clock_bus_i;
	logic               reset_i;
	logic [31:0]        comm_i;
	logic [31:0]        comm_o;
	logic               core_req_i;
	logic               core_rw_i;
	logic [`ADDR_W-1:0] core_addr_i;
	logic [`DATA_W-1:0] core_data_i;
	logic               core_done_o;
	logic [`DATA_W-1:0] core_data_o;
	logic [31:0]        pc_i;
	logic               mem_req_valid_o;
	logic               mem_req_write_o;
	logic [`ADDR_W-1:0] mem_req_addr_o;
	logic               mem_req_ready_i;
	logic               mem_wdata_valid_o;
	logic [`DATA_W-1:0] mem_wdata_o;
	logic               mem_wdata_ready_i;
	logic               mem_rdata_valid_i;
	logic [`DATA_W-1:0] mem_rdata_i;
	logic               mem_rdata_ready_o;

	logic [3:0]         comm_sel;
	logic               comm_clr;
	logic [`DATA_W-1:0] mem [MEM_WORDS];	// backing memory
	logic [`DATA_W-1:0] shadow [MEM_WORDS];	// data as the core last wrote it
	integer             seed;
	int                 err_cnt;
	int                 timeouts;
	int                 ref_idx;	// pc follows from the count of issued references
	logic               held;		// request parked behind a full sampler
	logic [31:0]        held_exp;

	cache_sampler_top UUT (
		.clock_bus_i       (clock_bus_i),
		.reset_i           (reset_i),
		.comm_i            (comm_i),
		.comm_o            (comm_o),
		.core_req_i        (core_req_i),
		.core_rw_i         (core_rw_i),
		.core_addr_i       (core_addr_i),
		.core_data_i       (core_data_i),
		.core_done_o       (core_done_o),
		.core_data_o       (core_data_o),
		.pc_i              (pc_i),
		.mem_req_valid_o   (mem_req_valid_o),
		.mem_req_write_o   (mem_req_write_o),
		.mem_req_addr_o    (mem_req_addr_o),
		.mem_req_ready_i   (mem_req_ready_i),
		.mem_wdata_valid_o (mem_wdata_valid_o),
		.mem_wdata_o       (mem_wdata_o),
		.mem_wdata_ready_i (mem_wdata_ready_i),
		.mem_rdata_valid_i (mem_rdata_valid_i),
		.mem_rdata_i       (mem_rdata_i),
		.mem_rdata_ready_o (mem_rdata_ready_o)
	);

	// counters always enabled
	always_comb begin
		comm_i                            = '0;
		comm_i[COMM_SEL_MSB:COMM_SEL_LSB] = comm_sel;
		comm_i[COMM_CNT_EN_BIT]           = 1'b1;
		comm_i[COMM_CLR_BIT]              = comm_clr;
	end

	initial begin
		clock_bus_i = 1'b0;
		forever #2 clock_bus_i = ~clock_bus_i;	// 4 ns period
	end

	// memory model
	// --------------------
	logic [`ADDR_W-1:0] rd_addr;
	logic [`ADDR_W-1:0] wr_addr;
	int                 rd_left;	// refill beats still owed
	logic               rd_xfer;

	initial begin
		seed              = 32'he6c73cb4;
		mem_req_ready_i   = 1'b0;
		mem_wdata_ready_i = 1'b0;
		mem_rdata_valid_i = 1'b0;
		mem_rdata_i       = '0;
		rd_addr           = '0;
		wr_addr           = '0;
		rd_left           = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[16'(i)]    = 32'(i) ^ 32'hA5A50000;	// pattern over the full address
			shadow[16'(i)] = 32'(i) ^ 32'hA5A50000;
		end
		forever begin
			@(posedge clock_bus_i);
			rd_xfer = mem_rdata_valid_i && mem_rdata_ready_o;
			if (mem_req_valid_o && mem_req_ready_i) begin
				if (mem_req_write_o) begin
					wr_addr = mem_req_addr_o;	// writeback block
				end else begin
					rd_addr = mem_req_addr_o;
					rd_left = `WORDS_PER_LINE;
				end
			end
			if (mem_wdata_valid_o && mem_wdata_ready_i) begin
				if (mem_wdata_o !== shadow[wr_addr]) begin
					$display("[FAIL] %0t mem_wdata_o @%h expected %h got %h", $time, wr_addr,
						shadow[wr_addr], mem_wdata_o);
					err_cnt++;
				end
				mem[wr_addr] = mem_wdata_o;
				wr_addr      = wr_addr + 1'b1;
			end
			if (rd_xfer) begin
				rd_addr = rd_addr + 1'b1;
				rd_left--;
			end
			#1;
			mem_req_ready_i   = (($random(seed) & 3) != 0);	// ready 3 of 4 cycles
			mem_wdata_ready_i = (($random(seed) & 3) != 0);
			if (rd_xfer) begin
				mem_rdata_valid_i = 1'b0;
			end
			if (rd_left > 0 && !mem_rdata_valid_i && (($random(seed) & 3) != 0)) begin
				mem_rdata_valid_i = 1'b1;	// held until taken
				mem_rdata_i       = mem[rd_addr];
			end
		end
	end

	// core driver
	// --------------------
	task automatic wait_done(output int lat, output bit ok);
		ok  = 1'b0;
		lat = 0;
		while (!ok && lat < DONE_TIMEOUT) begin
			@(posedge clock_bus_i);
			#1;
			lat++;
			ok = core_done_o;
		end
		if (!ok) begin
			$display("timeout at %0t, the core request got no done", $time);
			timeouts++;
		end
	endtask

	task automatic release_req();
		@(posedge clock_bus_i);	// dropped in the cycle after done
		#1;
		core_req_i = 1'b0;
	endtask

	task automatic core_access(input logic is_write, input logic [`ADDR_W-1:0] addr,
		input logic [31:0] data, input logic [31:0] lat_exp, input logic [31:0] exp);
		int lat;
		bit ok;
		@(posedge clock_bus_i);
		#1;
		core_req_i  = 1'b1;
		core_rw_i   = is_write;
		core_addr_i = addr;
		core_data_i = data;
		pc_i        = 32'h400 + 32'(ref_idx) * 32'd4;
		ref_idx++;
		if (is_write) begin
			shadow[addr] = data;
		end
		if (lat_exp == HELD) begin
			for (int i = 0; i < QUIET_CYCLES; i++) begin
				@(posedge clock_bus_i);
				#1;
				if (core_done_o) begin
					$display("[FAIL] %0t core_done_o while the sampler was full expected 0 got %b",
						$time, core_done_o);
					err_cnt++;
				end
			end
			held     = 1'b1;	// completes after the next clear
			held_exp = exp;
		end else begin
			wait_done(lat, ok);
			if (ok) begin
				if (lat_exp != 0 && 32'(lat) != lat_exp) begin
					$display("[FAIL] %0t core_done_o latency @%h expected %0d got %0d", $time,
						addr, lat_exp, lat);
					err_cnt++;
				end
				if (!is_write && core_data_o !== exp) begin
					$display("[FAIL] %0t core_data_o @%h expected %h got %h", $time, addr,
						exp, core_data_o);
					err_cnt++;
				end
				release_req();
			end
		end
	endtask

	task automatic comm_read(input logic [3:0] sel, input logic [31:0] exp);
		@(posedge clock_bus_i);
		#1;
		comm_sel = sel;
		@(posedge clock_bus_i);	// registered status word
		#1;
		if (comm_o !== exp) begin
			$display("[FAIL] %0t comm_o sel %0d expected %h got %h", $time, sel, exp, comm_o);
			err_cnt++;
		end
	endtask

	task automatic pulse_clear();
		int lat;
		bit ok;
		@(posedge clock_bus_i);
		#1;
		comm_clr = 1'b1;
		@(posedge clock_bus_i);
		#1;
		comm_clr = 1'b0;
		if (held) begin
			held = 1'b0;
			wait_done(lat, ok);
			if (ok) begin
				if (core_data_o !== held_exp) begin
					$display("[FAIL] %0t core_data_o held read expected %h got %h", $time,
						held_exp, core_data_o);
					err_cnt++;
				end
				release_req();
			end
		end
	endtask

	// golden file sequencer
	// --------------------
	int          fd;
	int          n;
	string       line;
	logic [7:0]  f_kind;
	logic [31:0] f_arg;
	logic [31:0] f_data;
	logic [31:0] f_exp;

	initial begin
		reset_i     = 1'b0;
		core_req_i  = 1'b0;
		core_rw_i   = 1'b0;
		core_addr_i = '0;
		core_data_i = '0;
		pc_i        = '0;
		comm_sel    = '0;
		comm_clr    = 1'b0;
		err_cnt     = 0;
		timeouts    = 0;
		ref_idx     = 0;
		held        = 1'b0;
		held_exp    = '0;
		repeat (2) @(posedge clock_bus_i);
		#1;
		reset_i = 1'b1;

		fd = $fopen("verif/cache_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file");
			err_cnt++;
		end else begin
			while (!$feof(fd) && timeouts == 0) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin	// skip blanks and comments
					n = $sscanf(line, "%s %h %h %h", f_kind, f_arg, f_data, f_exp);
					case (f_kind)
						"R": core_access(1'b0, f_arg[`ADDR_W-1:0], '0, f_data, f_exp);
						"W": core_access(1'b1, f_arg[`ADDR_W-1:0], f_data, '0, '0);
						"C": comm_read(f_arg[3:0], f_exp);
						"K": pulse_clear();
						default: begin
							$display("unknown operation kind in the golden file: %s", line);
							err_cnt++;
						end
					endcase
				end
			end
			$fclose(fd);
		end

		$display("value errors %0d, timeouts %0d, assertion failures %0d", err_cnt, timeouts,
			UUT.u_ctrl.u_asrt.fail_cnt);
		if (err_cnt == 0 && timeouts == 0 && UUT.u_ctrl.u_asrt.fail_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: verif/cache_assertions.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_assertions (
	input logic               clock_bus_i,
	input logic               reset_i,
	input logic               core_done_o,
	input logic               mem_req_valid_o,
	input logic               mem_req_write_o,
	input logic [`ADDR_W-1:0] mem_req_addr_o,
	input logic               mem_req_ready_i,
	input logic               mem_wdata_valid_o,
	input logic [`DATA_W-1:0] mem_wdata_o,
	input logic               mem_wdata_ready_i,
	input logic               stall_i
);
	int unsigned fail_cnt = 0;	// failures seen so far

	// done is a one-cycle pulse
	done_pulse: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		core_done_o |=> !core_done_o)
		else begin
			$error("core_done_o high for two cycles");
			fail_cnt++;
		end

	// request payload frozen while ready is low
	req_hold: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		mem_req_valid_o && !mem_req_ready_i |=>
		mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_write_o))
		else begin
			$error("memory request changed before its transfer");
			fail_cnt++;
		end

	wdata_hold: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		mem_wdata_valid_o && !mem_wdata_ready_i |=> mem_wdata_valid_o && $stable(mem_wdata_o))
		else begin
			$error("write data changed before its transfer");
			fail_cnt++;
		end

	// no lookup starts in a stalled cycle so no done follows two edges later
	no_accept_stall: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		$past(stall_i, 2) |-> !core_done_o)
		else begin
			$error("core request accepted while the sampler stalls");
			fail_cnt++;
		end

endmodule

bind cache_controller cache_assertions u_asrt (
	.clock_bus_i       (clock_bus_i),
	.reset_i           (reset_i),
	.core_done_o       (core_done_o),
	.mem_req_valid_o   (mem_req_valid_o),
	.mem_req_write_o   (mem_req_write_o),
	.mem_req_addr_o    (mem_req_addr_o),
	.mem_req_ready_i   (mem_req_ready_i),
	.mem_wdata_valid_o (mem_wdata_valid_o),
	.mem_wdata_o       (mem_wdata_o),
	.mem_wdata_ready_i (mem_wdata_ready_i),
	.stall_i           (stall_i)
);

// File: verilog/cache_sampler_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_sampler_top (
	input  logic               clock_bus_i,
	input  logic               reset_i,
	input  logic [31:0]        comm_i,
	output logic [31:0]        comm_o,
	// core
	input  logic               core_req_i,
	input  logic               core_rw_i,
	input  logic [`ADDR_W-1:0] core_addr_i,
	input  logic [`DATA_W-1:0] core_data_i,
	output logic               core_done_o,
	output logic [`DATA_W-1:0] core_data_o,
	input  logic [31:0]        pc_i,
	// memory
	output logic               mem_req_valid_o,
	output logic               mem_req_write_o,
	output logic [`ADDR_W-1:0] mem_req_addr_o,
	input  logic               mem_req_ready_i,
	output logic               mem_wdata_valid_o,
	output logic [`DATA_W-1:0] mem_wdata_o,
	input  logic               mem_wdata_ready_i,
	input  logic               mem_rdata_valid_i,
	input  logic [`DATA_W-1:0] mem_rdata_i,
	output logic               mem_rdata_ready_o
);
	logic               ref_accept;
	logic               sampler_stall;
	logic               sampler_full;
	logic               sampler_clear;
	logic               hit_evt;
	logic               miss_evt;
	logic               wb_evt;
	logic [31:0]        sample_count;
	logic [`ADDR_W-1:0] last_addr;
	logic [31:0]        last_pc;

	cache_controller u_ctrl (
		.clock_bus_i       (clock_bus_i),
		.reset_i           (reset_i),
		.core_req_i        (core_req_i),
		.core_rw_i         (core_rw_i),
		.core_addr_i       (core_addr_i),
		.core_data_i       (core_data_i),
		.core_done_o       (core_done_o),
		.core_data_o       (core_data_o),
		.mem_req_valid_o   (mem_req_valid_o),
		.mem_req_write_o   (mem_req_write_o),
		.mem_req_addr_o    (mem_req_addr_o),
		.mem_req_ready_i   (mem_req_ready_i),
		.mem_wdata_valid_o (mem_wdata_valid_o),
		.mem_wdata_o       (mem_wdata_o),
		.mem_wdata_ready_i (mem_wdata_ready_i),
		.mem_rdata_valid_i (mem_rdata_valid_i),
		.mem_rdata_i       (mem_rdata_i),
		.mem_rdata_ready_o (mem_rdata_ready_o),
		.stall_i           (sampler_stall),
		.ref_accept_o      (ref_accept),
		.hit_evt_o         (hit_evt),
		.miss_evt_o        (miss_evt),
		.wb_evt_o          (wb_evt)
	);

	// samples the same address and pc the controller accepted
	ref_sampler u_sampler (
		.clock_bus_i    (clock_bus_i),
		.reset_i        (reset_i),
		.ref_accept_i   (ref_accept),
		.ref_addr_i     (core_addr_i),
		.ref_pc_i       (pc_i),
		.clear_i        (sampler_clear),
		.sample_count_o (sample_count),
		.last_addr_o    (last_addr),
		.last_pc_o      (last_pc),
		.full_o         (sampler_full),
		.stall_o        (sampler_stall)
	);

	perf_comm u_comm (
		.clock_bus_i     (clock_bus_i),
		.reset_i         (reset_i),
		.comm_i          (comm_i),
		.comm_o          (comm_o),
		.hit_evt_i       (hit_evt),
		.miss_evt_i      (miss_evt),
		.wb_evt_i        (wb_evt),
		.sample_count_i  (sample_count),
		.last_addr_i     (last_addr),
		.last_pc_i       (last_pc),
		.sampler_full_i  (sampler_full),
		.sampler_clear_o (sampler_clear)
	);

endmodule

// File: verilog/perf_comm.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module perf_comm (
	input  logic               clock_bus_i,
	input  logic               reset_i,
	input  logic [31:0]        comm_i,
	output logic [31:0]        comm_o,
	input  logic               hit_evt_i,
	input  logic               miss_evt_i,
	input  logic               wb_evt_i,
	input  logic [31:0]        sample_count_i,
	input  logic [`ADDR_W-1:0] last_addr_i,
	input  logic [31:0]        last_pc_i,
	input  logic               sampler_full_i,
	output logic               sampler_clear_o
);
	import comm_pkg::*;

	comm_sel_t   sel;
	logic        cnt_en;
	logic [31:0] hit_cnt_q;
	logic [31:0] miss_cnt_q;
	logic [31:0] wb_cnt_q;

	assign sel             = comm_sel_t'(comm_i[COMM_SEL_MSB:COMM_SEL_LSB]);
	assign cnt_en          = comm_i[COMM_CNT_EN_BIT];
	assign sampler_clear_o = comm_i[COMM_CLR_BIT];

	// event counters
	// --------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			hit_cnt_q  <= '0;
			miss_cnt_q <= '0;
			wb_cnt_q   <= '0;
		end else if (cnt_en) begin
			hit_cnt_q  <= hit_cnt_q + 32'(hit_evt_i);
			miss_cnt_q <= miss_cnt_q + 32'(miss_evt_i);
			wb_cnt_q   <= wb_cnt_q + 32'(wb_evt_i);
		end
	end

	// status word, one cycle after the select
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			comm_o <= '0;
		end else begin
			case (sel)
				SEL_HITS:      comm_o <= hit_cnt_q;
				SEL_MISSES:    comm_o <= miss_cnt_q;
				SEL_WBS:       comm_o <= wb_cnt_q;
				SEL_SAMPLES:   comm_o <= sample_count_i;
				SEL_LAST_ADDR: comm_o <= 32'(last_addr_i);
				SEL_LAST_PC:   comm_o <= last_pc_i;
				SEL_ID:        comm_o <= `ID_CACHE_SAMPLER;
				SEL_FULL:      comm_o <= {31'd0, sampler_full_i};
				default:       comm_o <= '0;	// unused codes
			endcase
		end
	end

endmodule

// File: verilog/ref_sampler.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module ref_sampler (
	input  logic               clock_bus_i,
	input  logic               reset_i,
	input  logic               ref_accept_i,
	input  logic [`ADDR_W-1:0] ref_addr_i,
	input  logic [31:0]        ref_pc_i,
	input  logic               clear_i,
	output logic [31:0]        sample_count_o,
	output logic [`ADDR_W-1:0] last_addr_o,
	output logic [31:0]        last_pc_o,
	output logic               full_o,
	output logic               stall_o
);
	localparam int PER_W  = $clog2(`SAMPLE_PERIOD);
	localparam int PTR_W  = $clog2(`SAMPLE_DEPTH);
	localparam int FILL_W = $clog2(`SAMPLE_DEPTH + 1);

	logic [PER_W-1:0]   phase_q;	// refs since the last sample
	logic [PTR_W-1:0]   wr_ptr_q;
	logic [PTR_W-1:0]   last_ptr;
	logic [FILL_W-1:0]  fill_q;
	logic [31:0]        count_q;	// survives a clear
	logic               take;
	logic [`ADDR_W-1:0] addr_buf [`SAMPLE_DEPTH];
	logic [31:0]        pc_buf [`SAMPLE_DEPTH];

	assign take = ref_accept_i && (phase_q == PER_W'(`SAMPLE_PERIOD - 1));

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			phase_q  <= '0;
			wr_ptr_q <= '0;
			fill_q   <= '0;
			count_q  <= '0;
		end else begin
			if (ref_accept_i) begin
				phase_q <= take ? '0 : phase_q + 1'b1;
			end
			if (clear_i) begin
				wr_ptr_q <= '0;	// empty the buffer
				fill_q   <= '0;
			end else if (take) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
				fill_q   <= fill_q + 1'b1;
			end
			if (take) begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	// sample buffer
	always_ff @(posedge clock_bus_i) begin
		if (take && !clear_i) begin
			addr_buf[wr_ptr_q] <= ref_addr_i;
			pc_buf[wr_ptr_q]   <= ref_pc_i;
		end
	end

	assign last_ptr       = wr_ptr_q - 1'b1;	// most recent entry
	assign last_addr_o    = addr_buf[last_ptr];
	assign last_pc_o      = pc_buf[last_ptr];
	assign sample_count_o = count_q;
	assign full_o         = (fill_q == FILL_W'(`SAMPLE_DEPTH));
	assign stall_o        = full_o;	// hold the core until drained

endmodule

// File: verilog/cache_controller.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_controller (
	input  logic               clock_bus_i,
	input  logic               reset_i,
	// core side
	input  logic               core_req_i,
	input  logic               core_rw_i,		// 1 = write
	input  logic [`ADDR_W-1:0] core_addr_i,
	input  logic [`DATA_W-1:0] core_data_i,
	output logic               core_done_o,
	output logic [`DATA_W-1:0] core_data_o,
	// memory request channel
	output logic               mem_req_valid_o,
	output logic               mem_req_write_o,
	output logic [`ADDR_W-1:0] mem_req_addr_o,
	input  logic               mem_req_ready_i,
	// memory write data
	output logic               mem_wdata_valid_o,
	output logic [`DATA_W-1:0] mem_wdata_o,
	input  logic               mem_wdata_ready_i,
	// memory read data
	input  logic               mem_rdata_valid_i,
	input  logic [`DATA_W-1:0] mem_rdata_i,
	output logic               mem_rdata_ready_o,
	// sampler
	input  logic               stall_i,
	output logic               ref_accept_o,
	// events
	output logic               hit_evt_o,
	output logic               miss_evt_o,
	output logic               wb_evt_o
);
	import cache_pkg::*;

	localparam word_off_t ZERO_OFF = '0;
	localparam word_off_t LAST_OFF = word_off_t'(`WORDS_PER_LINE - 1);

	ctrl_state_t             state_q;
	tag_t                    req_tag;
	word_off_t               req_off;
	line_idx_t               rr_ptr_q;		// next victim, round robin
	word_off_t               beat_q;		// word within the block transfer
	word_off_t               next_beat;
	logic [`CACHE_LINES-1:0] dirty_q;
	logic                    retry_q;		// refill done, replay the request
	logic                    hit_pend_q;	// ram access issued, done next edge
	logic                    done_q;
	logic                    take;
	logic                    rfl_beat;
	logic                    tag_wr;

	// tag store
	logic                    cam_hit;
	line_idx_t               cam_hit_idx;
	tag_t                    victim_tag;

	// data ram controls
	logic                    ram_we_q;
	logic [IDX_W+OFF_W-1:0]  ram_addr_q;
	logic [`DATA_W-1:0]      ram_wdata_q;
	logic [`DATA_W-1:0]      ram_rdata;

	// memory channel registers
	logic                    mem_req_valid_q;
	logic                    mem_req_write_q;
	logic [`ADDR_W-1:0]      mem_req_addr_q;
	logic                    mem_wdata_valid_q;
	logic                    mem_rdata_ready_q;

	logic                    hit_evt_q;
	logic                    miss_evt_q;
	logic                    wb_evt_q;

	assign req_tag   = core_addr_i[`ADDR_W-1:OFF_W];
	assign req_off   = core_addr_i[OFF_W-1:0];
	assign next_beat = beat_q + 1'b1;

	// new request or retry, never while stalled or a done is pending
	assign take = (state_q == IDLE) && (core_req_i || retry_q) && !stall_i
		&& !hit_pend_q && !done_q;
	assign ref_accept_o = take && !retry_q;	// original request only
	assign rfl_beat     = (state_q == REFILL) && mem_rdata_valid_i && mem_rdata_ready_q;
	assign tag_wr       = rfl_beat && (beat_q == LAST_OFF);	// tag lands with last word

	tag_cam u_tag_cam (
		.clock_bus_i  (clock_bus_i),
		.reset_i      (reset_i),
		.lookup_tag_i (req_tag),
		.wr_en_i      (tag_wr),
		.wr_idx_i     (rr_ptr_q),
		.wr_tag_i     (req_tag),
		.rd_idx_i     (rr_ptr_q),
		.hit_o        (cam_hit),
		.hit_idx_o    (cam_hit_idx),
		.rd_tag_o     (victim_tag)
	);

	data_ram u_data_ram (
		.clock_bus_i (clock_bus_i),
		.wr_en_i     (ram_we_q),
		.addr_i      (ram_addr_q),
		.wdata_i     (ram_wdata_q),
		.rdata_o     (ram_rdata)
	);

	// controller
	// --------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state_q           <= IDLE;
			rr_ptr_q          <= '0;
			beat_q            <= '0;
			dirty_q           <= '0;
			retry_q           <= 1'b0;
			hit_pend_q        <= 1'b0;
			done_q            <= 1'b0;
			ram_we_q          <= 1'b0;
			mem_req_valid_q   <= 1'b0;
			mem_wdata_valid_q <= 1'b0;
			mem_rdata_ready_q <= 1'b0;
			hit_evt_q         <= 1'b0;
			miss_evt_q        <= 1'b0;
			wb_evt_q          <= 1'b0;
		end else begin
			ram_we_q   <= 1'b0;
			hit_evt_q  <= 1'b0;
			miss_evt_q <= 1'b0;
			wb_evt_q   <= 1'b0;
			done_q     <= hit_pend_q;	// ram access this edge, done with it
			hit_pend_q <= 1'b0;

			case (state_q)
				IDLE: begin
					if (take) begin
						retry_q <= 1'b0;
						if (cam_hit) begin
							hit_evt_q   <= 1'b1;
							hit_pend_q  <= 1'b1;
							ram_we_q    <= core_rw_i;
							ram_addr_q  <= {cam_hit_idx, req_off};
							ram_wdata_q <= core_data_i;
							if (core_rw_i) begin
								dirty_q[cam_hit_idx] <= 1'b1;
							end
						end else begin
							miss_evt_q      <= !retry_q;
							mem_req_valid_q <= 1'b1;
							mem_req_write_q <= dirty_q[rr_ptr_q];	// victim out first
							mem_req_addr_q  <= dirty_q[rr_ptr_q] ? {victim_tag, ZERO_OFF}
								: {req_tag, ZERO_OFF};
							state_q         <= WAIT_REQ;
						end
					end
				end

				WAIT_REQ: begin
					if (mem_req_ready_i) begin
						mem_req_valid_q <= 1'b0;
						beat_q          <= '0;
						if (mem_req_write_q) begin
							ram_addr_q <= {rr_ptr_q, ZERO_OFF};	// fetch word 0
							state_q    <= WB_DATA;
						end else begin
							mem_rdata_ready_q <= 1'b1;
							state_q           <= REFILL;
						end
					end
				end

				// two cycles per beat, ram read then offer
				WB_DATA: begin
					if (!mem_wdata_valid_q) begin
						mem_wdata_valid_q <= 1'b1;	// ram word settles at this edge
					end else if (mem_wdata_ready_i) begin
						mem_wdata_valid_q <= 1'b0;
						if (beat_q == LAST_OFF) begin
							dirty_q[rr_ptr_q] <= 1'b0;
							wb_evt_q          <= 1'b1;
							mem_req_valid_q   <= 1'b1;	// now the refill request
							mem_req_write_q   <= 1'b0;
							mem_req_addr_q    <= {req_tag, ZERO_OFF};
							state_q           <= WAIT_REQ;
						end else begin
							beat_q     <= next_beat;
							ram_addr_q <= {rr_ptr_q, next_beat};
						end
					end
				end

				REFILL: begin
					if (rfl_beat) begin
						ram_we_q    <= 1'b1;
						ram_addr_q  <= {rr_ptr_q, beat_q};
						ram_wdata_q <= mem_rdata_i;
						beat_q      <= next_beat;
						if (beat_q == LAST_OFF) begin
							mem_rdata_ready_q <= 1'b0;
							rr_ptr_q          <= rr_ptr_q + 1'b1;
							retry_q           <= 1'b1;
							state_q           <= IDLE;
						end
					end
				end

				default: state_q <= IDLE;
			endcase
		end
	end

	assign core_done_o       = done_q;
	assign core_data_o       = ram_rdata;
	assign mem_req_valid_o   = mem_req_valid_q;
	assign mem_req_write_o   = mem_req_write_q;
	assign mem_req_addr_o    = mem_req_addr_q;
	assign mem_wdata_valid_o = mem_wdata_valid_q;
	assign mem_wdata_o       = ram_rdata;	// held while the address is held
	assign mem_rdata_ready_o = mem_rdata_ready_q;
	assign hit_evt_o         = hit_evt_q;
	assign miss_evt_o        = miss_evt_q;
	assign wb_evt_o          = wb_evt_q;

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module data_ram (
	input  logic                                         clock_bus_i,
	input  logic                                         wr_en_i,
	input  logic [cache_pkg::IDX_W+cache_pkg::OFF_W-1:0] addr_i,	// {line, word}
	input  logic [`DATA_W-1:0]                           wdata_i,
	output logic [`DATA_W-1:0]                           rdata_o
);
	import cache_pkg::*;

	localparam int N_WORDS = 2 ** (IDX_W + OFF_W);

	logic [`DATA_W-1:0] mem_q [N_WORDS];

	// registered read, old data on a write cycle
	always_ff @(posedge clock_bus_i) begin
		if (wr_en_i) begin
			mem_q[addr_i] <= wdata_i;
		end
		rdata_o <= mem_q[addr_i];
	end

endmodule

// File: verilog/tag_cam.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module tag_cam (
	input  logic                 clock_bus_i,
	input  logic                 reset_i,
	input  cache_pkg::tag_t      lookup_tag_i,
	input  logic                 wr_en_i,
	input  cache_pkg::line_idx_t wr_idx_i,
	input  cache_pkg::tag_t      wr_tag_i,
	input  cache_pkg::line_idx_t rd_idx_i,
	output logic                 hit_o,
	output cache_pkg::line_idx_t hit_idx_o,
	output cache_pkg::tag_t      rd_tag_o
);
	import cache_pkg::*;

	tag_t                    tag_q [`CACHE_LINES];	// block tag per line
	logic [`CACHE_LINES-1:0] valid_q;

	// parallel compare against every valid line
	always_comb begin
		hit_o     = 1'b0;
		hit_idx_o = '0;
		for (int i = 0; i < `CACHE_LINES; i++) begin
			if (valid_q[i] && (tag_q[i] == lookup_tag_i)) begin
				hit_o     = 1'b1;
				hit_idx_o = line_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			valid_q <= '0;	// cold cache
		end else if (wr_en_i) begin
			valid_q[wr_idx_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (wr_en_i) begin
			tag_q[wr_idx_i] <= wr_tag_i;
		end
	end

	assign rd_tag_o = tag_q[rd_idx_i];	// victim tag for writeback address

endmodule

// File: verilog/comm_pkg.sv
package comm_pkg;

	// status word select, comm_i[3:0]
	typedef enum logic [3:0] {
		SEL_HITS      = 4'd0,
		SEL_MISSES    = 4'd1,
		SEL_WBS       = 4'd2,
		SEL_SAMPLES   = 4'd3,	// samples taken so far
		SEL_LAST_ADDR = 4'd4,
		SEL_LAST_PC   = 4'd5,
		SEL_ID        = 4'd6,
		SEL_FULL      = 4'd7	// sampler buffer full
	} comm_sel_t;

	// comm_i field positions
	localparam int COMM_SEL_LSB    = 0;
	localparam int COMM_SEL_MSB    = 3;
	localparam int COMM_CNT_EN_BIT = 4;	// counters run while set
	localparam int COMM_CLR_BIT    = 5;	// sampler clear, pulsed

endpackage

// File: verilog/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

	// widths derived from the geometry macros
	localparam int IDX_W = $clog2(`CACHE_LINES);
	localparam int OFF_W = $clog2(`WORDS_PER_LINE);
	localparam int TAG_W = `ADDR_W - OFF_W;	// no index field, full block number

	// controller states
	typedef enum logic [1:0] {
		IDLE,		// lookup, hit service, retry
		WAIT_REQ,	// memory request waiting for ready
		WB_DATA,	// dirty victim streaming out
		REFILL		// new block streaming in
	} ctrl_state_t;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] line_idx_t;
	typedef logic [OFF_W-1:0] word_off_t;

endpackage

// File: verilog/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
`define CACHE_LINES      4            // any line holds any block
`define WORDS_PER_LINE   4
`define ADDR_W           16           // word address
`define DATA_W           32

// reference sampler
`define SAMPLE_PERIOD    4            // record one ref out of this many
`define SAMPLE_DEPTH     4            // sample buffer entries

// status port
`define ID_CACHE_SAMPLER 32'h0CA5_0001 // system id, comm select 6

`endif
